// ==== sources.f ====
logic/wr_req_pkg.sv
logic/wr_data_pkg.sv
logic/fifo_stream.sv
logic/reg_slice.sv
logic/dest_wr_req_arb.sv
logic/dest_wr_data_mux.sv
logic/dest_wr_top.sv
tests/dest_wr_monitor.sv
tests/dest_wr_chk.sv
tests/tb_dest_wr.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_dest_wr
FILELIST = sources.f
LOG      = sim.log
FAIL_MSG = Finished with errors
PASS_MSG = Finished with no errors

.PHONY: compile run clean

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== tests/tb_dest_wr.sv ====
// Testbench top for the write path: clock, reset, stimulus table, LFSR, watchdog and summary

`timescale 1ns/1ns

module tb_dest_wr;

    localparam int N_ROWS = 7;

    // One stimulus row, each masked destination sends reps requests
    typedef struct packed {
        logic [3:0]       mask;
        logic [1:0]       reps;
        logic [7:0]       stall;
        logic [5:0]       pid_base;
        logic [3:0][15:0] len;
    } row_t;

    logic aclk = 1'b0;
    logic aresetn;
    logic [wr_req_pkg::N_DESTS-1:0]                    s_req_valid;
    logic [wr_req_pkg::N_DESTS-1:0]                    s_req_ready;
    wr_req_pkg::wr_req_t [wr_req_pkg::N_DESTS-1:0]     s_req;
    logic                                              m_req_valid;
    logic                                              m_req_ready;
    wr_req_pkg::wr_req_t                               m_req;
    logic [wr_req_pkg::N_DESTS-1:0]                    s_data_valid;
    logic [wr_req_pkg::N_DESTS-1:0]                    s_data_ready;
    wr_data_pkg::data_beat_t [wr_req_pkg::N_DESTS-1:0] s_data;
    logic                                              m_data_valid;
    logic                                              m_data_ready;
    wr_data_pkg::data_beat_t                           m_data;
    logic [wr_req_pkg::PID_BITS-1:0]                   m_data_pid;
    logic                                              row_end;
    int                                                row_num;
    int                                                errors;
    int                                                rows_failed;

    row_t        rows [N_ROWS];
    logic [31:0] lfsr_q = 32'h239f_5cd7;

    // 20 ns period
    always #10 aclk = ~aclk;

    dest_wr_top dut_i (.*);

    dest_wr_monitor mon_i (.*);

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic row_t make_row(input logic [3:0] mask, input int reps, input int stall,
                                      input int pid_base, input int l0, input int l1,
                                      input int l2, input int l3);
        row_t r;
        r.mask = mask;
        r.reps = 2'(reps);
        r.stall = 8'(stall);
        r.pid_base = 6'(pid_base);
        r.len[0] = 16'(l0);
        r.len[1] = 16'(l1);
        r.len[2] = 16'(l2);
        r.len[3] = 16'(l3);
        return r;
    endfunction

    // Beats per request, 8 bytes each
    function automatic int beats_of(input logic [15:0] len);
        return ((int'(len) - 1) >> 3) + 1;
    endfunction

    // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[62:0], lfsr_q[0]};
        end
    endtask

    // ------------------------------
    // Watchdog
    // ------------------------------

    initial begin
        longint limit;
        int max_beats;
        int b;
        @(posedge aresetn);
        max_beats = 1;
        for (int r = 0; r < N_ROWS; r++) begin
            for (int d = 0; d < wr_req_pkg::N_DESTS; d++) begin
                if (rows[r].mask[d]) begin
                    b = int'(rows[r].reps) * beats_of(rows[r].len[d]);
                    if (b > max_beats) begin
                        max_beats = b;
                    end
                end
            end
        end
        limit = longint'(N_ROWS) * (wr_req_pkg::N_DESTS * max_beats + 20) * 4 * 20;
        #(limit);
        $display("Timeout: the write path stopped moving before all rows completed");
        $display("Finished with errors");
        $finish;
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        int req_left [wr_req_pkg::N_DESTS];
        int rep [wr_req_pkg::N_DESTS];
        int pend [wr_req_pkg::N_DESTS];
        logic busy [wr_req_pkg::N_DESTS];
        int total;
        int done;
        int reqs_out;
        int cyc;
        logic [63:0] bits;
        // Reset, order 0..3, sparse masks, repeats, long FIFO stall
        rows[0] = make_row(4'hF, 1, 0, 1, 8, 16, 24, 32);
        rows[1] = make_row(4'h5, 1, 0, 10, 1, 40, 8, 8);
        rows[2] = make_row(4'hA, 1, 0, 20, 8, 17, 8, 64);
        rows[3] = make_row(4'hB, 2, 0, 30, 64, 9, 8, 33);
        rows[4] = make_row(4'hF, 3, 60, 40, 8, 8, 8, 8);
        rows[5] = make_row(4'h6, 1, 0, 50, 8, 57, 3, 8);
        rows[6] = make_row(4'hF, 2, 5, 12, 12, 1, 48, 25);
        aresetn = 1'b0;
        s_req_valid = '0;
        s_req = '0;
        s_data_valid = '0;
        s_data = '0;
        m_req_ready = 1'b0;
        m_data_ready = 1'b0;
        row_end = 1'b0;
        row_num = 0;
        repeat (4) @(posedge aclk);
        aresetn <= 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            total = 0;
            done = 0;
            reqs_out = 0;
            cyc = 0;
            for (int d = 0; d < wr_req_pkg::N_DESTS; d++) begin
                req_left[d] = rows[r].mask[d] ? int'(rows[r].reps) : 0;
                rep[d] = 0;
                pend[d] = 0;
                busy[d] = 1'b0;
                total += req_left[d];
            end
            // Row ends once every request and every final beat has left
            while (done < total || reqs_out < total) begin
                @(posedge aclk);
                for (int d = 0; d < wr_req_pkg::N_DESTS; d++) begin
                    s_req_valid[d] <= (req_left[d] > 0);
                    s_req[d].vaddr <= {16'(16'hA000 + r), 16'(d), 16'(rep[d])};
                    s_req[d].len <= rows[r].len[d];
                    s_req[d].pid <= 6'(int'(rows[r].pid_base) + d + 8 * rep[d]);
                    if (!busy[d] && pend[d] > 0) begin
                        take_bits(64, bits);
                        busy[d] = 1'b1;
                        s_data_valid[d] <= 1'b1;
                        s_data[d].data <= bits;
                        // Random incoming last, the DUT must ignore it
                        take_bits(1, bits);
                        s_data[d].last <= bits[0];
                    end else if (!busy[d]) begin
                        s_data_valid[d] <= 1'b0;
                    end
                end
                take_bits(2, bits);
                m_req_ready <= |bits[1:0];
                take_bits(2, bits);
                m_data_ready <= (cyc < int'(rows[r].stall)) ? 1'b0 : |bits[1:0];
                @(negedge aclk);
                for (int d = 0; d < wr_req_pkg::N_DESTS; d++) begin
                    if (s_req_valid[d] && s_req_ready[d]) begin
                        req_left[d]--;
                        rep[d]++;
                        pend[d] += beats_of(rows[r].len[d]);
                    end
                    if (s_data_valid[d] && s_data_ready[d]) begin
                        pend[d]--;
                        busy[d] = 1'b0;
                    end
                end
                if (m_req_valid && m_req_ready) begin
                    reqs_out++;
                end
                if (m_data_valid && m_data_ready && m_data.last) begin
                    done++;
                end
                cyc++;
            end
            @(posedge aclk);
            row_end <= 1'b1;
            row_num <= r;
            @(posedge aclk);
            row_end <= 1'b0;
        end
        repeat (2) @(posedge aclk);
        $display("Rows run: %0d, rows failed: %0d, errors: %0d, assertion failures: %0d",
                 N_ROWS, rows_failed, errors, dut_i.chk_i.fail_cnt);
        if (errors == 0 && dut_i.chk_i.fail_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== tests/dest_wr_chk.sv ====
// Concurrent assertions on handshake and reset behavior, bound into the write path top

`timescale 1ns/1ns

module dest_wr_chk (
    input logic                                          aclk,
    input logic                                          aresetn,
    input logic [wr_req_pkg::N_DESTS-1:0]                s_req_valid,
    input logic [wr_req_pkg::N_DESTS-1:0]                s_req_ready,
    input wr_req_pkg::wr_req_t [wr_req_pkg::N_DESTS-1:0] s_req,
    input logic                                          m_req_valid,
    input logic                                          m_req_ready,
    input wr_req_pkg::wr_req_t                           m_req,
    input logic                                          m_data_valid,
    input logic                                          m_data_ready,
    input wr_data_pkg::data_beat_t                       m_data,
    input logic [wr_req_pkg::PID_BITS-1:0]               m_data_pid
);

    // Beat count of every grant whose data has not all left
    int beats_q [$];
    int out_cnt;
    int head_beats;
    int fail_cnt = 0;

    always @(posedge aclk) begin
        if (!aresetn) begin
            out_cnt <= 0;
            beats_q.delete();
        end else begin
            if (m_data_valid && m_data_ready && beats_q.size() != 0) begin
                if (out_cnt + 1 == beats_q[0]) begin
                    out_cnt <= 0;
                    void'(beats_q.pop_front());
                end else begin
                    out_cnt <= out_cnt + 1;
                end
            end
            for (int d = 0; d < wr_req_pkg::N_DESTS; d++) begin
                if (s_req_valid[d] && s_req_ready[d]) begin
                    // 8 bytes per beat, a partial beat counts whole
                    beats_q.push_back((int'(s_req[d].len) + 7) / 8);
                end
            end
        end
    end

    always_comb begin
        head_beats = (beats_q.size() != 0) ? beats_q[0] : 0;
    end

    // ------------------------------
    // Rules
    // ------------------------------

    a_reset_quiet: assert property (@(posedge aclk) !aresetn |=> !m_req_valid && !m_data_valid)
        else begin
            $error("valid output high after reset");
            fail_cnt++;
        end

    a_req_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        m_req_valid && !m_req_ready |=> m_req_valid && $stable(m_req))
        else begin
            $error("m_req changed while stalled");
            fail_cnt++;
        end

    a_data_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        m_data_valid && !m_data_ready |=> m_data_valid && $stable(m_data) && $stable(m_data_pid))
        else begin
            $error("m_data changed while stalled");
            fail_cnt++;
        end

    a_last_final: assert property (@(posedge aclk) disable iff (!aresetn)
        m_data_valid |-> (m_data.last == (out_cnt + 1 == head_beats)))
        else begin
            $error("last does not match the final beat of its grant");
            fail_cnt++;
        end

endmodule

bind dest_wr_top dest_wr_chk chk_i (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .s_req_valid (s_req_valid),
    .s_req_ready (s_req_ready),
    .s_req       (s_req),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_req       (m_req),
    .m_data_valid(m_data_valid),
    .m_data_ready(m_data_ready),
    .m_data      (m_data),
    .m_data_pid  (m_data_pid)
);

// ==== tests/dest_wr_monitor.sv ====
// Checker for the write path, models round-robin order and compares requests and beats

`timescale 1ns/1ns

module dest_wr_monitor (
    input  logic                                              aclk,
    input  logic                                              aresetn,
    input  logic [wr_req_pkg::N_DESTS-1:0]                    s_req_valid,
    input  logic [wr_req_pkg::N_DESTS-1:0]                    s_req_ready,
    input  wr_req_pkg::wr_req_t [wr_req_pkg::N_DESTS-1:0]     s_req,
    input  logic                                              m_req_valid,
    input  logic                                              m_req_ready,
    input  wr_req_pkg::wr_req_t                               m_req,
    input  logic [wr_req_pkg::N_DESTS-1:0]                    s_data_valid,
    input  logic [wr_req_pkg::N_DESTS-1:0]                    s_data_ready,
    input  wr_data_pkg::data_beat_t [wr_req_pkg::N_DESTS-1:0] s_data,
    input  logic                                              m_data_valid,
    input  logic                                              m_data_ready,
    input  wr_data_pkg::data_beat_t                           m_data,
    input  logic [wr_req_pkg::PID_BITS-1:0]                   m_data_pid,
    input  logic                                              row_end,
    input  int                                                row_num,
    output int                                                errors,
    output int                                                rows_failed
);

    // Model state
    int                  rr_ptr;
    wr_req_pkg::wr_req_t exp_req [$];
    int                  g_dest [$];
    logic [5:0]          g_pid [$];
    int                  g_beats [$];
    logic [63:0]         data_q [wr_req_pkg::N_DESTS][$];
    int                  beat_idx;
    int                  row_errors;
    int                  row_grants;

    initial begin
        rr_ptr = 0;
        beat_idx = 0;
        errors = 0;
        rows_failed = 0;
        row_errors = 0;
        row_grants = 0;
    end

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors++;
        row_errors++;
    endtask

    // First valid at or after the pointer
    function automatic int predict(input logic [3:0] v, input int p);
        for (int i = 0; i < wr_req_pkg::N_DESTS; i++) begin
            if (v[(p + i) % wr_req_pkg::N_DESTS]) begin
                return (p + i) % wr_req_pkg::N_DESTS;
            end
        end
        return -1;
    endfunction

    // Handshakes are stable at the falling edge
    always @(negedge aclk) begin
        int pick;
        int d;
        logic [63:0] want;
        wr_req_pkg::wr_req_t exp;
        if (aresetn) begin
            // ------------------------------
            // Output beats
            // ------------------------------
            if (m_data_valid && m_data_ready) begin
                if (g_dest.size() == 0) begin
                    report_fail("data beat with no grant pending");
                end else begin
                    d = g_dest[0];
                    want = (data_q[d].size() != 0) ? data_q[d].pop_front() : 'x;
                    if (m_data.data !== want) begin
                        report_fail($sformatf("beat data %h, expected %h", m_data.data, want));
                    end
                    if (m_data_pid !== g_pid[0]) begin
                        report_fail($sformatf("beat pid %0d, expected %0d", m_data_pid, g_pid[0]));
                    end
                    if (m_data.last !== (beat_idx == g_beats[0] - 1)) begin
                        report_fail($sformatf("last=%b on beat %0d of %0d", m_data.last,
                                              beat_idx, g_beats[0]));
                    end
                    beat_idx++;
                    if (beat_idx == g_beats[0]) begin
                        beat_idx = 0;
                        void'(g_dest.pop_front());
                        void'(g_pid.pop_front());
                        void'(g_beats.pop_front());
                    end
                end
            end
            // Input beats per destination
            for (int i = 0; i < wr_req_pkg::N_DESTS; i++) begin
                if (s_data_valid[i] && s_data_ready[i]) begin
                    data_q[i].push_back(s_data[i].data);
                end
            end
            // ------------------------------
            // Grants and requests
            // ------------------------------
            for (int i = 0; i < wr_req_pkg::N_DESTS; i++) begin
                if (s_req_valid[i] && s_req_ready[i]) begin
                    pick = predict(s_req_valid, rr_ptr);
                    if (pick != i) begin
                        report_fail($sformatf("grant to %0d, expected %0d", i, pick));
                    end
                    exp_req.push_back(s_req[i]);
                    g_dest.push_back(i);
                    g_pid.push_back(s_req[i].pid);
                    g_beats.push_back(((int'(s_req[i].len) - 1) >> 3) + 1);
                    rr_ptr = (rr_ptr + 1) % wr_req_pkg::N_DESTS;
                    row_grants++;
                end
            end
            if (g_dest.size() > wr_data_pkg::N_OUTSTANDING + 1) begin
                report_fail("more grants outstanding than the sequence FIFO holds");
            end
            if (m_req_valid && m_req_ready) begin
                if (exp_req.size() == 0) begin
                    report_fail("request left m_req with none expected");
                end else begin
                    exp = exp_req.pop_front();
                    if (m_req !== exp) begin
                        report_fail($sformatf("request %h, expected %h", m_req, exp));
                    end
                end
            end
            // Row summary
            if (row_end) begin
                if (exp_req.size() != 0 || g_dest.size() != 0) begin
                    $display("Row %0d left requests or beats that never came out", row_num);
                    errors++;
                    row_errors++;
                end
                if (row_errors == 0) begin
                    $display("Row %0d ok, %0d grants", row_num, row_grants);
                end else begin
                    $display("Row %0d failed, %0d errors", row_num, row_errors);
                    rows_failed++;
                end
                row_errors = 0;
                row_grants = 0;
            end
        end
    end

endmodule

// ==== logic/dest_wr_top.sv ====
// Write path top, arbiter feeds the sequence FIFO that drives the data mux

`timescale 1ns/1ns

module dest_wr_top (
    input  logic aclk,
    input  logic aresetn,

    // Destination requests
    input  logic [wr_req_pkg::N_DESTS-1:0]                      s_req_valid,
    output logic [wr_req_pkg::N_DESTS-1:0]                      s_req_ready,
    input  wr_req_pkg::wr_req_t [wr_req_pkg::N_DESTS-1:0]       s_req,

    // Arbitrated request
    output logic                                                m_req_valid,
    input  logic                                                m_req_ready,
    output wr_req_pkg::wr_req_t                                 m_req,

    // Destination data
    input  logic [wr_req_pkg::N_DESTS-1:0]                      s_data_valid,
    output logic [wr_req_pkg::N_DESTS-1:0]                      s_data_ready,
    input  wr_data_pkg::data_beat_t [wr_req_pkg::N_DESTS-1:0]   s_data,

    // Merged data
    output logic                                                m_data_valid,
    input  logic                                                m_data_ready,
    output wr_data_pkg::data_beat_t                             m_data,
    output logic [wr_req_pkg::PID_BITS-1:0]                     m_data_pid
);

    // ------------------------------
    // Sequence channel
    // ------------------------------

    logic                  seq_in_valid;
    logic                  seq_in_ready;
    wr_data_pkg::mux_seq_t seq_in;
    logic                  seq_valid;
    logic                  seq_ready;
    wr_data_pkg::mux_seq_t seq;

    dest_wr_req_arb arb_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .s_req_valid (s_req_valid),
        .s_req_ready (s_req_ready),
        .s_req       (s_req),
        .m_req_valid (m_req_valid),
        .m_req_ready (m_req_ready),
        .m_req       (m_req),
        .seq_in_valid(seq_in_valid),
        .seq_in_ready(seq_in_ready),
        .seq_in      (seq_in)
    );

    // Grants waiting for their data
    fifo_stream #(
        .QTYPE(wr_data_pkg::mux_seq_t)
    ) seq_fifo_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .val_snk (seq_in_valid),
        .rdy_snk (seq_in_ready),
        .data_snk(seq_in),
        .val_src (seq_valid),
        .rdy_src (seq_ready),
        .data_src(seq)
    );

    dest_wr_data_mux mux_i (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .seq_valid   (seq_valid),
        .seq_ready   (seq_ready),
        .seq         (seq),
        .s_data_valid(s_data_valid),
        .s_data_ready(s_data_ready),
        .s_data      (s_data),
        .m_data_valid(m_data_valid),
        .m_data_ready(m_data_ready),
        .m_data      (m_data),
        .m_data_pid  (m_data_pid)
    );

endmodule

// ==== logic/dest_wr_data_mux.sv ====
// Write data steering from the head sequence entry, counts beats and marks the last one

`timescale 1ns/1ns

module dest_wr_data_mux (
    input  logic aclk,
    input  logic aresetn,

    // Sequence queue read side
    input  logic                                                seq_valid,
    output logic                                                seq_ready,
    input  wr_data_pkg::mux_seq_t                               seq,

    // Destination data
    input  logic [wr_req_pkg::N_DESTS-1:0]                      s_data_valid,
    output logic [wr_req_pkg::N_DESTS-1:0]                      s_data_ready,
    input  wr_data_pkg::data_beat_t [wr_req_pkg::N_DESTS-1:0]   s_data,

    // Merged data out
    output logic                                                m_data_valid,
    input  logic                                                m_data_ready,
    output wr_data_pkg::data_beat_t                             m_data,
    output logic [wr_req_pkg::PID_BITS-1:0]                     m_data_pid
);

    // Beat plus its owner, carried through the output stage
    typedef struct packed {
        wr_data_pkg::data_beat_t          beat;
        logic [wr_req_pkg::PID_BITS-1:0]  pid;
    } beat_pid_t;

    // ------------------------------
    // Steering
    // ------------------------------

    logic [wr_req_pkg::LEN_BITS-1:0] beat_cnt;
    logic                            slice_s_ready;
    logic                            in_valid;
    logic                            in_xfer;
    logic                            is_last;
    beat_pid_t                       in_beat;
    beat_pid_t                       out_beat;

    // Only the head entry's destination may pass
    assign in_valid = seq_valid && s_data_valid[seq.dest];
    assign in_xfer = in_valid && slice_s_ready;
    assign is_last = (beat_cnt == seq.n_tr);

    always_comb begin
        s_data_ready = '0;
        s_data_ready[seq.dest] = seq_valid && slice_s_ready;
    end

    // Incoming last bit dropped, regenerated from the count
    assign in_beat.beat.data = s_data[seq.dest].data;
    assign in_beat.beat.last = is_last;
    assign in_beat.pid = seq.pid;

    // Pop the entry with its final beat
    assign seq_ready = in_xfer && is_last;

    // Beat counter for the head entry
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            beat_cnt <= '0;
        end else if (in_xfer) begin
            if (is_last) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Output stage, one cycle per beat
    reg_slice #(
        .STYPE(beat_pid_t)
    ) data_slice_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .s_valid  (in_valid),
        .s_ready  (slice_s_ready),
        .s_payload(in_beat),
        .m_valid  (m_data_valid),
        .m_ready  (m_data_ready),
        .m_payload(out_beat)
    );

    assign m_data = out_beat.beat;
    assign m_data_pid = out_beat.pid;

endmodule

// ==== logic/dest_wr_req_arb.sv ====
// Round-robin write request arbiter, one sequence entry per grant for the data mux

`timescale 1ns/1ns

module dest_wr_req_arb (
    input  logic aclk,
    input  logic aresetn,

    // Destination requests
    input  logic [wr_req_pkg::N_DESTS-1:0]                      s_req_valid,
    output logic [wr_req_pkg::N_DESTS-1:0]                      s_req_ready,
    input  wr_req_pkg::wr_req_t [wr_req_pkg::N_DESTS-1:0]       s_req,

    // Arbitrated request out
    output logic                                                m_req_valid,
    input  logic                                                m_req_ready,
    output wr_req_pkg::wr_req_t                                 m_req,

    // Sequence queue write side
    output logic                                                seq_in_valid,
    input  logic                                                seq_in_ready,
    output wr_data_pkg::mux_seq_t                               seq_in
);

    // ------------------------------
    // Internal signals
    // ------------------------------

    logic [wr_req_pkg::DEST_BITS-1:0] rr_ptr;
    logic [wr_req_pkg::DEST_BITS-1:0] dest_sel;
    logic                             any_valid;
    wr_req_pkg::wr_req_t              req_sel;
    logic                             slice_s_ready;
    logic                             grant;
    logic [wr_req_pkg::LEN_BITS-1:0]  n_tr;

    // ------------------------------
    // Round-robin pick
    // ------------------------------

    // First valid destination at or after the pointer, wrapping
    always_comb begin
        int unsigned idx;
        logic found;
        found = 1'b0;
        dest_sel = '0;
        for (int i = 0; i < wr_req_pkg::N_DESTS; i++) begin
            idx = (int'(rr_ptr) + i) % wr_req_pkg::N_DESTS;
            if (!found && s_req_valid[idx]) begin
                found = 1'b1;
                dest_sel = wr_req_pkg::DEST_BITS'(idx);
            end
        end
        any_valid = found;
    end

    assign req_sel = s_req[dest_sel];

    // Request and sequence entry move together or not at all
    assign grant = any_valid && slice_s_ready && seq_in_ready;

    // Ready back to the chosen destination only
    always_comb begin
        s_req_ready = '0;
        s_req_ready[dest_sel] = slice_s_ready && seq_in_ready;
    end

    // Pointer steps by one per grant, not to grantee plus one
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rr_ptr <= '0;
        end else if (grant) begin
            if (rr_ptr == wr_req_pkg::DEST_BITS'(wr_req_pkg::N_DESTS - 1)) begin
                rr_ptr <= '0;
            end else begin
                rr_ptr <= rr_ptr + 1'b1;
            end
        end
    end

    // ------------------------------
    // Sequence entry
    // ------------------------------

    // Beats minus one from the byte length
    assign n_tr = (req_sel.len - wr_req_pkg::LEN_BITS'(1)) >> wr_data_pkg::BEAT_LOG_BITS;

    assign seq_in_valid = any_valid && slice_s_ready;
    assign seq_in.pid = req_sel.pid;
    assign seq_in.dest = dest_sel;
    assign seq_in.n_tr = n_tr;

    // Output request stage, one cycle latency
    reg_slice #(
        .STYPE(wr_req_pkg::wr_req_t)
    ) req_slice_i (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .s_valid  (any_valid && seq_in_ready),
        .s_ready  (slice_s_ready),
        .s_payload(req_sel),
        .m_valid  (m_req_valid),
        .m_ready  (m_req_ready),
        .m_payload(m_req)
    );

endmodule

// ==== logic/reg_slice.sv ====
// Single-stage valid/ready register slice for any payload type, full throughput

`timescale 1ns/1ns

module reg_slice #(
    parameter type STYPE = logic
) (
    input  logic aclk,
    input  logic aresetn,

    // Upstream
    input  logic s_valid,
    output logic s_ready,
    input  STYPE s_payload,

    // Downstream
    output logic m_valid,
    input  logic m_ready,
    output STYPE m_payload
);

    // ------------------------------
    // Stage registers
    // ------------------------------

    logic valid_q;
    STYPE payload_q;

    // Stage can load when empty or when drained this cycle
    assign s_ready = !valid_q || m_ready;

    assign m_valid = valid_q;
    assign m_payload = payload_q;

    // Valid follows the input whenever the stage may load
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            valid_q <= 1'b0;
        end else if (s_ready) begin
            valid_q <= s_valid;
        end
    end

    // Payload taken only on a transfer, held while stalled
    always_ff @(posedge aclk) begin
        if (s_valid && s_ready) begin
            payload_q <= s_payload;
        end
    end

endmodule

// ==== logic/fifo_stream.sv ====
// Valid/ready FIFO for any payload type, sized by the outstanding-grant depth

`timescale 1ns/1ns

module fifo_stream #(
    parameter type QTYPE = logic
) (
    input  logic aclk,
    input  logic aresetn,

    // Write side
    input  logic val_snk,
    output logic rdy_snk,
    input  QTYPE data_snk,

    // Read side
    output logic val_src,
    input  logic rdy_src,
    output QTYPE data_src
);

    // ------------------------------
    // Storage and pointers
    // ------------------------------

    QTYPE mem [wr_data_pkg::N_OUTSTANDING];

    logic [wr_data_pkg::SEQ_PTR_BITS-1:0] wr_ptr;
    logic [wr_data_pkg::SEQ_PTR_BITS-1:0] rd_ptr;

    // One extra bit so a full queue is representable
    logic [wr_data_pkg::SEQ_PTR_BITS:0] count;

    logic push;
    logic pop;

    // Ready drops only when every slot holds an entry
    assign rdy_snk = (count != (wr_data_pkg::SEQ_PTR_BITS + 1)'(wr_data_pkg::N_OUTSTANDING));

    // Head is valid whenever something is stored
    assign val_src = (count != '0);
    assign data_src = mem[rd_ptr];

    assign push = val_snk && rdy_snk;
    assign pop = val_src && rdy_src;

    // ------------------------------
    // Control state
    // ------------------------------

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            // Pointers wrap on their own, depth is a power of two
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Entry write
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= data_snk;
        end
    end

endmodule

// ==== logic/wr_data_pkg.sv ====
// Data-side types and sizes for write beats and the arbiter-to-mux sequence queue

package wr_data_pkg;

    // ------------------------------
    // Beat sizing
    // ------------------------------

    // Width of one write data beat
    localparam int DATA_BITS = 64;

    // log2 of bytes per beat, 8 bytes here
    localparam int BEAT_LOG_BITS = 3;

    // ------------------------------
    // Sequence queue sizing
    // ------------------------------

    // Grants that may wait for their data
    localparam int N_OUTSTANDING = 8;

    // Read and write pointer width of the sequence queue
    localparam int SEQ_PTR_BITS = $clog2(N_OUTSTANDING);

    // One beat on the write data channel
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic                 last;
    } data_beat_t;

    // Sequence entry, one per grant
    // n_tr is beat count minus one
    typedef struct packed {
        logic [wr_req_pkg::PID_BITS-1:0]  pid;
        logic [wr_req_pkg::DEST_BITS-1:0] dest;
        logic [wr_req_pkg::LEN_BITS-1:0]  n_tr;
    } mux_seq_t;

endpackage

// ==== logic/wr_req_pkg.sv ====
// Request-side types and sizes shared by the write arbiter, the top level and the testbench

package wr_req_pkg;

    // ------------------------------
    // Destination sizing
    // ------------------------------

    // Number of user destinations on the write path
    localparam int N_DESTS = 4;

    // Destination index, also the round-robin pointer width
    localparam int DEST_BITS = 2;

    // ------------------------------
    // Request field widths
    // ------------------------------

    // Process id carried with every request
    localparam int PID_BITS = 6;

    // Byte length of one request
    localparam int LEN_BITS = 16;

    // Virtual address width
    localparam int VADDR_BITS = 48;

    // One write request from a destination
    // len is in bytes, never zero
    typedef struct packed {
        logic [VADDR_BITS-1:0] vaddr;
        logic [LEN_BITS-1:0]   len;
        logic [PID_BITS-1:0]   pid;
    } wr_req_t;

endpackage
